//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP   = tb_mips_top
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;                    // data word and byte address
    typedef logic [4:0]  reg_idx_t;                 // register number
    typedef logic [7:0]  mem_addr_t;                // word index into one memory

    localparam word_t text_start = 32'h0040_0000;   // instruction memory base
    localparam word_t data_start = 32'h1000_8000;   // data memory base
    localparam int    mem_words  = 256;             // depth of each memory

    localparam logic [5:0] funct_add = 6'h20;       // r-type funct codes
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2a;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_reg = 2'd0,                             // value read in decode
        fwd_wb  = 2'd1,                             // writeback data
        fwd_mem = 2'd2                              // ex/mem alu result
    } fwd_sel_t;

    typedef struct packed {
        word_t instr;
        word_t pc4;
    } if_id_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     alu_src;                          // immediate as operand b
        logic     reg_dst;                          // rd rather than rt
        alu_op_t  alu_op;
        word_t    pc4;
        word_t    rda;
        word_t    rdb;
        word_t    imm;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     zero;
        word_t    target;                           // beq destination
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        word_t    load_data;
        word_t    alu_result;
        reg_idx_t dest;
    } mem_wb_t;

endpackage

//--- core/decode_unit.sv
module decode_unit (
    input  mips_pkg::word_t    instr,
    output logic               reg_write,
    output logic               mem_to_reg,
    output logic               mem_read,
    output logic               mem_write,
    output logic               branch,
    output logic               alu_src,
    output logic               reg_dst,
    output mips_pkg::alu_op_t  alu_op,
    output mips_pkg::reg_idx_t rs,
    output mips_pkg::reg_idx_t rt,
    output mips_pkg::reg_idx_t rd,
    output mips_pkg::word_t    imm
);

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = {{16{instr[15]}}, instr[15:0]};    // sign extended offset

    always_comb begin
        reg_write  = 1'b0;                          // default is a nop
        mem_to_reg = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        alu_src    = 1'b0;
        reg_dst    = 1'b0;
        alu_op     = mips_pkg::alu_add;
        case (mips_pkg::opcode_t'(instr[31:26]))
            mips_pkg::op_rtype: begin
                reg_write = 1'b1;
                reg_dst   = 1'b1;
                case (instr[5:0])
                    mips_pkg::funct_add: alu_op = mips_pkg::alu_add;
                    mips_pkg::funct_sub: alu_op = mips_pkg::alu_sub;
                    mips_pkg::funct_and: alu_op = mips_pkg::alu_and;
                    mips_pkg::funct_or:  alu_op = mips_pkg::alu_or;
                    mips_pkg::funct_slt: alu_op = mips_pkg::alu_slt;
                    default: begin
                        reg_write = 1'b0;           // sll and friends, incl. all-zero word
                        reg_dst   = 1'b0;
                    end
                endcase
            end
            mips_pkg::op_lw: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                alu_src    = 1'b1;                  // base plus offset
            end
            mips_pkg::op_sw: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            mips_pkg::op_beq: begin
                branch = 1'b1;
                alu_op = mips_pkg::alu_sub;         // zero flag means equal
            end
            default: ;
        endcase
    end

endmodule

//--- core/execute_unit.sv
module execute_unit (
    input  mips_pkg::id_ex_t   ex,
    input  mips_pkg::fwd_sel_t fwd_a,
    input  mips_pkg::fwd_sel_t fwd_b,
    input  mips_pkg::word_t    mem_fwd,             // alu result in ex/mem
    input  mips_pkg::word_t    wb_fwd,              // data being written back
    output mips_pkg::ex_mem_t  result
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t rt_val;                        // forwarded rt, also store data
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_y;

    function automatic mips_pkg::word_t pick(input mips_pkg::fwd_sel_t sel,
                                             input mips_pkg::word_t reg_val);
        case (sel)
            mips_pkg::fwd_mem: return mem_fwd;
            mips_pkg::fwd_wb:  return wb_fwd;
            default:           return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a   = pick(fwd_a, ex.rda);
        rt_val = pick(fwd_b, ex.rdb);
    end

    assign op_b = ex.alu_src ? ex.imm : rt_val;

    always_comb begin
        case (ex.alu_op)
            mips_pkg::alu_sub: alu_y = op_a - op_b;
            mips_pkg::alu_and: alu_y = op_a & op_b;
            mips_pkg::alu_or:  alu_y = op_a | op_b;
            mips_pkg::alu_slt: alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            default:           alu_y = op_a + op_b;
        endcase
    end

    always_comb begin
        result.reg_write  = ex.reg_write;
        result.mem_to_reg = ex.mem_to_reg;
        result.mem_read   = ex.mem_read;
        result.mem_write  = ex.mem_write;
        result.branch     = ex.branch;
        result.zero       = (alu_y == '0);
        result.target     = ex.pc4 + {ex.imm[29:0], 2'b00};   // word offset to bytes
        result.alu_result = alu_y;
        result.store_data = rt_val;
        result.dest       = ex.reg_dst ? ex.rd : ex.rt;
    end

endmodule

//--- core/hazard_unit.sv
module hazard_unit (
    input  mips_pkg::reg_idx_t id_rs,
    input  mips_pkg::reg_idx_t id_rt,
    input  mips_pkg::reg_idx_t ex_rs,
    input  mips_pkg::reg_idx_t ex_rt,
    input  mips_pkg::reg_idx_t ex_rt_dest,          // load destination in ex
    input  mips_pkg::reg_idx_t mem_dest,
    input  mips_pkg::reg_idx_t wb_dest,
    input  logic               ex_mem_read,
    input  logic               mem_reg_write,
    input  logic               wb_reg_write,
    input  logic               branch_taken,
    output mips_pkg::fwd_sel_t fwd_a,
    output mips_pkg::fwd_sel_t fwd_b,
    output logic               stall,
    output logic               flush_front
);

    function automatic mips_pkg::fwd_sel_t fwd_for(input mips_pkg::reg_idx_t src);
        if (src == '0) begin
            return mips_pkg::fwd_reg;               // r0 is never forwarded
        end else if (mem_reg_write && mem_dest == src) begin
            return mips_pkg::fwd_mem;               // youngest result wins
        end else if (wb_reg_write && wb_dest == src) begin
            return mips_pkg::fwd_wb;
        end
        return mips_pkg::fwd_reg;
    endfunction

    always_comb begin
        fwd_a = fwd_for(ex_rs);
        fwd_b = fwd_for(ex_rt);
    end

    // load in ex with its result needed by the instruction in decode
    assign stall = ex_mem_read && (ex_rt_dest != '0) &&
                   (ex_rt_dest == id_rs || ex_rt_dest == id_rt);

    assign flush_front = branch_taken;              // kill if, id and ex

endmodule

//--- core/mips_core.sv
module mips_core (
    input  logic               clk,
    input  logic               rstn,
    input  logic               run,
    output mips_pkg::word_t    imem_addr,
    input  mips_pkg::word_t    imem_rdata,
    output mips_pkg::word_t    dmem_addr,
    output mips_pkg::word_t    dmem_wdata,
    output logic               dmem_we,
    output logic               dmem_re,
    input  mips_pkg::word_t    dmem_rdata,
    output logic               wb_valid,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data
);

    mips_pkg::word_t    pc;
    mips_pkg::word_t    pc4;
    mips_pkg::word_t    wb_value;                   // load data or alu result
    mips_pkg::if_id_t   if_id_d, if_id_q;
    mips_pkg::id_ex_t   id_ex_d, id_ex_q;
    mips_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
    mips_pkg::mem_wb_t  mem_wb_d, mem_wb_q;
    mips_pkg::fwd_sel_t fwd_a, fwd_b;
    logic               stall, flush_front, branch_taken, idle;

    logic               dec_reg_write, dec_mem_to_reg, dec_mem_read, dec_mem_write;
    logic               dec_branch, dec_alu_src, dec_reg_dst;
    mips_pkg::alu_op_t  dec_alu_op;
    mips_pkg::reg_idx_t dec_rs, dec_rt, dec_rd;
    mips_pkg::word_t    dec_imm, rf_rda, rf_rdb;

    assign idle         = !run;                     // pipeline parked while loading
    assign pc4          = pc + 32'd4;
    assign branch_taken = ex_mem_q.branch && ex_mem_q.zero;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= mips_pkg::text_start;
        end else if (idle) begin
            pc <= mips_pkg::text_start;
        end else if (branch_taken) begin
            pc <= ex_mem_q.target;                  // beq resolved in mem
        end else if (!stall) begin
            pc <= pc4;
        end
    end

    assign imem_addr = pc;
    assign if_id_d   = '{instr: imem_rdata, pc4: pc4};

    stage_reg #(.payload_t(mips_pkg::if_id_t)) u_if_id (
        .clk(clk), .rstn(rstn), .hold(stall), .flush(flush_front || idle),
        .d(if_id_d), .q(if_id_q)
    );

    decode_unit u_decode (
        .instr(if_id_q.instr), .reg_write(dec_reg_write), .mem_to_reg(dec_mem_to_reg),
        .mem_read(dec_mem_read), .mem_write(dec_mem_write), .branch(dec_branch),
        .alu_src(dec_alu_src), .reg_dst(dec_reg_dst), .alu_op(dec_alu_op),
        .rs(dec_rs), .rt(dec_rt), .rd(dec_rd), .imm(dec_imm)
    );

    reg_file u_reg_file (
        .clk(clk), .rstn(rstn), .ra(dec_rs), .rb(dec_rt), .wa(mem_wb_q.dest),
        .we(mem_wb_q.reg_write), .wd(wb_value), .rda(rf_rda), .rdb(rf_rdb)
    );

    assign id_ex_d = '{reg_write: dec_reg_write, mem_to_reg: dec_mem_to_reg,
                       mem_read: dec_mem_read, mem_write: dec_mem_write,
                       branch: dec_branch, alu_src: dec_alu_src, reg_dst: dec_reg_dst,
                       alu_op: dec_alu_op, pc4: if_id_q.pc4, rda: rf_rda, rdb: rf_rdb,
                       imm: dec_imm, rs: dec_rs, rt: dec_rt, rd: dec_rd};

    stage_reg #(.payload_t(mips_pkg::id_ex_t)) u_id_ex (
        .clk(clk), .rstn(rstn), .hold(1'b0), .flush(stall || flush_front || idle),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit u_execute (
        .ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(ex_mem_q.alu_result),
        .wb_fwd(wb_value), .result(ex_mem_d)
    );

    hazard_unit u_hazard (
        .id_rs(dec_rs), .id_rt(dec_rt), .ex_rs(id_ex_q.rs), .ex_rt(id_ex_q.rt),
        .ex_rt_dest(ex_mem_d.dest), .mem_dest(ex_mem_q.dest), .wb_dest(mem_wb_q.dest),
        .ex_mem_read(id_ex_q.mem_read), .mem_reg_write(ex_mem_q.reg_write),
        .wb_reg_write(mem_wb_q.reg_write), .branch_taken(branch_taken),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush_front(flush_front)
    );

    stage_reg #(.payload_t(mips_pkg::ex_mem_t)) u_ex_mem (
        .clk(clk), .rstn(rstn), .hold(1'b0), .flush(flush_front || idle),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_we    = ex_mem_q.mem_write;
    assign dmem_re    = ex_mem_q.mem_read;

    assign mem_wb_d = '{reg_write: ex_mem_q.reg_write, mem_to_reg: ex_mem_q.mem_to_reg,
                        load_data: dmem_rdata, alu_result: ex_mem_q.alu_result,
                        dest: ex_mem_q.dest};

    stage_reg #(.payload_t(mips_pkg::mem_wb_t)) u_mem_wb (
        .clk(clk), .rstn(rstn), .hold(1'b0), .flush(idle),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    assign wb_value = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    // trace of committed writes, r0 writes are dropped
    assign wb_valid = mem_wb_q.reg_write && (mem_wb_q.dest != '0);
    assign wb_reg   = mem_wb_q.dest;
    assign wb_data  = wb_value;

endmodule

//--- core/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               rstn,
    input  mips_pkg::reg_idx_t ra,
    input  mips_pkg::reg_idx_t rb,
    input  mips_pkg::reg_idx_t wa,
    input  logic               we,
    input  mips_pkg::word_t    wd,
    output mips_pkg::word_t    rda,
    output mips_pkg::word_t    rdb
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    function automatic mips_pkg::word_t rd_port(input mips_pkg::reg_idx_t a);
        if (a == '0) begin
            return '0;
        end else if (we && a == wa) begin
            return wd;                              // same-cycle write shows through
        end
        return regs[a];
    endfunction

    always_comb begin
        rda = rd_port(ra);
        rdb = rd_port(rb);
    end

endmodule

//--- flist.f
common/mips_pkg.sv
verilog/stage_reg.sv
core/decode_unit.sv
core/execute_unit.sv
core/hazard_unit.sv
core/reg_file.sv
core/mips_core.sv
verilog/mem_apb_port.sv
verilog/mips_top.sv
sim/mips_assertions.sv
sim/tb_mips_top.sv

//--- sim/mips_assertions.sv
module mips_assertions (
    input logic               clk,
    input logic               rstn,
    input logic               run,
    input logic               psel,
    input logic               penable,
    input logic               pslverr,
    input logic               wb_valid,
    input mips_pkg::reg_idx_t wb_reg,
    input mips_pkg::word_t    imem_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;                             // summed into the closing line of the run

    // r0 writes never reach the trace
    trace_reg_nonzero: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid |-> (wb_reg != '0))
        else begin
            fail_count++;
            $error("trace reports a write to r0");
        end

    // slave error only comes back in the access cycle
    slverr_in_access: assert property (@(posedge clk) disable iff (!rstn)
        pslverr |-> (psel && penable))
        else begin
            fail_count++;
            $error("pslverr high outside an apb access phase");
        end

    // one parked edge puts the pc back on the text base
    fetch_parked: assert property (@(posedge clk) disable iff (!rstn)
        (!run && !$past(run)) |-> (imem_addr == mips_pkg::text_start))
        else begin
            fail_count++;
            $error("fetch address left the text base while the core is parked");
        end

endmodule

//--- sim/mips_testdata.hex
// tag addr/reg value: P = program word, D = data word loaded before run,
// T = expected trace write (register, value) in program order, M = final data word
P 00400000 8c010000 // lw  $1, 0($0)   low offsets alias onto data word 0
P 00400004 8c220004 // lw  $2, 4($1)   load-use on $1
P 00400008 8c230008 // lw  $3, 8($1)
P 0040000c 00432020 // add $4, $2, $3  load-use on $3
P 00400010 00822822 // sub $5, $4, $2  $4 from ex/mem
P 00400014 00853025 // or  $6, $4, $5  $4 from mem/wb, $5 from ex/mem
P 00400018 00c43824 // and $7, $6, $4
P 0040001c 00a4402a // slt $8, $5, $4
P 00400020 ac27000c // sw  $7, 12($1)  store data from mem/wb
P 00400024 10c60003 // beq $6, $6, +3  taken
P 00400028 00844820 // add $9, $4, $4  flushed
P 0040002c 00845020 // add $10, $4, $4 flushed
P 00400030 00845820 // add $11, $4, $4 flushed
P 00400034 01076020 // add $12, $8, $7 branch target
P 00400038 8c2d000c // lw  $13, 12($1)
P 0040003c 01ac7020 // add $14, $13, $12
P 00400040 ac2e0010 // sw  $14, 16($1)
P 00400044 00087822 // sub $15, $0, $8
P 00400048 01e0802a // slt $16, $15, $0
P 0040004c 1000ffff // beq $0, $0, -1  park loop
P 00400050 00000000
P 00400054 00000000
P 00400058 00000000
D 10008000 10008000
D 10008004 00000007
D 10008008 0000000c
T 01 10008000
T 02 00000007
T 03 0000000c
T 04 00000013
T 05 0000000c
T 06 0000001f
T 07 00000013
T 08 00000001
T 0c 00000014
T 0d 00000013
T 0e 00000027
T 0f ffffffff
T 10 00000001
M 10008000 10008000
M 10008004 00000007
M 10008008 0000000c
M 1000800c 00000013
M 10008010 00000027

//--- sim/tb_mips_top.sv
module tb_mips_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half     = 2;                // 4 ns clock
    localparam int reset_cycles = 16;
    localparam int run_limit    = 2000;             // cycles allowed for the whole trace
    localparam int ready_limit  = 16;               // cycles allowed for pready

    logic               clk;
    logic               rstn;
    logic               run;
    logic               psel;
    logic               penable;
    logic               pwrite;
    mips_pkg::word_t    paddr;
    mips_pkg::word_t    pwdata;
    mips_pkg::word_t    prdata;
    logic               pready;
    logic               pslverr;
    logic               wb_valid;
    mips_pkg::reg_idx_t wb_reg;
    mips_pkg::word_t    wb_data;

    mips_pkg::word_t    prog_addr[$];               // P lines
    mips_pkg::word_t    prog_word[$];
    mips_pkg::word_t    data_addr[$];               // D lines preload data memory before run
    mips_pkg::word_t    data_word[$];
    mips_pkg::reg_idx_t exp_reg[$];                 // T lines in program order
    mips_pkg::word_t    exp_val[$];
    mips_pkg::word_t    mem_addr[$];                // M lines hold the final data memory
    mips_pkg::word_t    mem_word[$];

    int                 errors;
    int                 checks;
    int                 timeouts;
    logic               started;                    // core has been let go
    int                 trace_idx    = 0;           // owned by the trace monitor
    int                 trace_errors = 0;
    int                 trace_checks = 0;

    mips_top u_mips_top (
        .clk(clk), .rstn(rstn), .run(run),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    bind mips_top mips_assertions u_assertions (
        .clk(clk), .rstn(rstn), .run(run), .psel(psel), .penable(penable),
        .pslverr(pslverr), .wb_valid(wb_valid), .wb_reg(wb_reg), .imem_addr(imem_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    task automatic check_word(input string what, input mips_pkg::word_t addr,
                              input mips_pkg::word_t got, input mips_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error @ %0d ns: %s at %h is %h, expected %h",
                     $time, what, addr, got, exp);
        end
    endtask

    task automatic load_testdata();
        int              fd;
        int              n;
        string           line;
        byte             tag;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        fd = $fopen("sim/mips_testdata.hex", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the test data file sim/mips_testdata.hex");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%c %h %h", tag, a, b);   // comment lines give n < 3
                if (n == 3) begin
                    case (tag)
                        "P": begin
                            prog_addr.push_back(a);
                            prog_word.push_back(b);
                        end
                        "D": begin
                            data_addr.push_back(a);
                            data_word.push_back(b);
                        end
                        "T": begin
                            exp_reg.push_back(a[4:0]);
                            exp_val.push_back(b);
                        end
                        "M": begin
                            mem_addr.push_back(a);
                            mem_word.push_back(b);
                        end
                        default: ;
                    endcase
                end
            end
        end
        $fclose(fd);
    endtask

    // one apb transfer of a setup and an access cycle, sampled mid access
    task automatic apb_access(input logic wr, input mips_pkg::word_t addr,
                              input mips_pkg::word_t wdata,
                              output mips_pkg::word_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waited < ready_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            timeouts++;
            $display("timeout: pready stayed low for the transfer at %h", addr);
        end
        rdata = prdata;                             // registered at the setup edge
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_word(input mips_pkg::word_t addr, input mips_pkg::word_t data,
                              input logic exp_err);
        mips_pkg::word_t ignored;
        logic            err;
        apb_access(1'b1, addr, data, ignored, err);
        check_word("pslverr on write", addr, 32'(err), 32'(exp_err));
    endtask

    task automatic read_word(input mips_pkg::word_t addr, output mips_pkg::word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_word("pslverr on read", addr, 32'(err), 32'd0);
    endtask

    task automatic wait_for_trace(output logic done);
        int cycles;
        cycles = 0;
        while (trace_idx < exp_reg.size() && cycles < run_limit) begin
            @(posedge clk);
            cycles++;
        end
        done = (trace_idx >= exp_reg.size());
        if (!done) begin
            timeouts++;
            $display("timeout: only %0d of %0d trace entries seen after %0d cycles",
                     trace_idx, exp_reg.size(), cycles);
        end
    endtask

    // trace monitor runs mid cycle where the mem/wb outputs are settled
    always @(negedge clk) begin
        if (rstn && wb_valid) begin
            trace_checks++;
            assert (started) else begin
                trace_errors++;
                $display("** Error @ %0d ns: trace write r%0d before the core was started",
                         $time, wb_reg);
            end
            assert (trace_idx < exp_reg.size()) else begin
                trace_errors++;                     // e.g. a flushed slot that got through
                $display("** Error @ %0d ns: unexpected trace write r%0d = %h",
                         $time, wb_reg, wb_data);
            end
            if (trace_idx < exp_reg.size()) begin
                assert (wb_reg == exp_reg[trace_idx] && wb_data === exp_val[trace_idx])
                else begin
                    trace_errors++;
                    $display("** Error @ %0d ns: trace entry %0d is r%0d = %h, expected r%0d = %h",
                             $time, trace_idx, wb_reg, wb_data,
                             exp_reg[trace_idx], exp_val[trace_idx]);
                end
                trace_idx++;
            end
        end
    end

    initial begin
        mips_pkg::word_t rdata;
        logic            done;
        rstn     = 1'b0;
        run      = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        started  = 1'b0;
        load_testdata();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rstn = 1'b1;

        foreach (prog_addr[i]) begin
            write_word(prog_addr[i], prog_word[i], 1'b0);   // imem loads while parked
        end
        foreach (data_addr[i]) begin
            write_word(data_addr[i], data_word[i], 1'b0);
            read_word(data_addr[i], rdata);
            check_word("data readback", data_addr[i], rdata, data_word[i]);
        end

        @(posedge clk);
        #1;
        started = 1'b1;
        run     = 1'b1;
        wait_for_trace(done);

        if (done && mem_addr.size() > 0) begin
            // refused while running so the M check below still sees the old word
            write_word(mem_addr[0], ~mem_word[0], 1'b1);
            repeat (8) @(posedge clk);              // room for stray trace writes
            #1;
            run = 1'b0;
            foreach (mem_addr[i]) begin
                read_word(mem_addr[i], rdata);
                check_word("final data", mem_addr[i], rdata, mem_word[i]);
            end
        end

        $display("checks %0d, errors %0d, assert fails %0d, timeouts %0d, trace %0d of %0d",
                 checks + trace_checks, errors + trace_errors,
                 u_mips_top.u_assertions.fail_count, timeouts, trace_idx, exp_reg.size());
        if (errors + trace_errors == 0 && u_mips_top.u_assertions.fail_count == 0 &&
            timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/mem_apb_port.sv
module mem_apb_port (
    input  logic            clk,
    input  logic            rstn,
    input  logic            run,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  mips_pkg::word_t paddr,
    input  mips_pkg::word_t pwdata,
    output mips_pkg::word_t prdata,
    output logic            pready,
    output logic            pslverr,
    input  mips_pkg::word_t imem_addr,
    output mips_pkg::word_t imem_rdata,
    input  mips_pkg::word_t dmem_addr,
    input  mips_pkg::word_t dmem_wdata,
    input  logic            dmem_we,
    input  logic            dmem_re,
    output mips_pkg::word_t dmem_rdata
);

    mips_pkg::word_t     imem [mips_pkg::mem_words];
    mips_pkg::word_t     dmem [mips_pkg::mem_words];

    logic                setup, apb_wr, in_text, in_data;
    mips_pkg::mem_addr_t apb_iidx, apb_didx, core_iidx, core_didx;

    function automatic mips_pkg::mem_addr_t word_idx(input mips_pkg::word_t addr,
                                                     input mips_pkg::word_t base);
        mips_pkg::word_t off;
        off = addr - base;
        return off[2 +: $bits(mips_pkg::mem_addr_t)];   // drop byte offset
    endfunction

    assign setup   = psel && !penable;
    assign apb_wr  = psel && penable && pwrite && !run;  // writes only while parked
    assign in_text = (paddr >= mips_pkg::text_start) && (paddr < mips_pkg::data_start);
    assign in_data = (paddr >= mips_pkg::data_start);

    always_comb begin
        apb_iidx  = word_idx(paddr, mips_pkg::text_start);
        apb_didx  = word_idx(paddr, mips_pkg::data_start);
        core_iidx = word_idx(imem_addr, mips_pkg::text_start);
        core_didx = word_idx(dmem_addr, mips_pkg::data_start);
    end

    assign pready     = 1'b1;                       // zero wait states
    assign imem_rdata = imem[core_iidx];            // combinational fetch
    assign dmem_rdata = dmem_re ? dmem[core_didx] : '0;

    always_ff @(posedge clk) begin
        if (apb_wr && in_text) begin
            imem[apb_iidx] <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[core_didx] <= dmem_wdata;          // sw from mem stage
        end else if (apb_wr && in_data) begin
            dmem[apb_didx] <= pwdata;
        end
    end

    // sampled in setup so both are valid through the access cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && run;
            if (setup && !pwrite) begin
                prdata <= (in_data && !run) ? dmem[apb_didx] : '0;
            end
        end
    end

endmodule

//--- verilog/mips_top.sv
module mips_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               run,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  mips_pkg::word_t    paddr,
    input  mips_pkg::word_t    pwdata,
    output mips_pkg::word_t    prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               wb_valid,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data
);

    mips_pkg::word_t imem_addr, imem_rdata;
    mips_pkg::word_t dmem_addr, dmem_wdata, dmem_rdata;
    logic            dmem_we, dmem_re;

    mips_core u_core (
        .clk(clk), .rstn(rstn), .run(run),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_re(dmem_re), .dmem_rdata(dmem_rdata),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    mem_apb_port u_mem (
        .clk(clk), .rstn(rstn), .run(run),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_re(dmem_re), .dmem_rdata(dmem_rdata)
    );

endmodule

//--- verilog/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     hold,                          // keep current payload
    input  logic     flush,                         // load a bubble, wins over hold
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;                                // all controls inactive
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule
